// File: ocs_controller.f
ocs_pkg.sv
ocs_slot_ctrl.sv
slot_event_fifo.sv
ocs_sync_tx.sv
ocs_controller.sv
tb_ocs_controller.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_ocs_controller -f ocs_controller.f

out=$(./obj_dir/Vtb_ocs_controller)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// File: tb_ocs_controller.sv
`timescale 1ns/100ps

module tb_ocs_controller;

import ocs_pkg::*;

localparam int SLOT_LEN     = 40;
localparam int CONFIG_DELAY = 12;
localparam int FIFO_DEPTH   = 4;
localparam int SLOT_PERIOD  = SLOT_LEN + CONFIG_DELAY;

logic                   i_clk;
logic                   i_rst;
logic [CHANNEL_NUM-1:0] i_chnl_ready;
logic [CHANNEL_NUM-1:0] i_tx_ready;
axis_beat_t             o_tx [CHANNEL_NUM];
logic [CHANNEL_NUM-1:0] o_tx_valid;
logic                   o_slot_id;
logic                   o_slot_start;

integer seed;
int     checks;
int     mismatches;
int     failures;
logic   aborted;

// Reference model state updated on the falling edge
logic                   prev_rst = 1'b1;
logic                   prev_all_ready = 1'b0;
logic                   model_idle = 1'b1;
int                     since_pulse = 0;
logic                   exp_id = 1'b0;
logic                   pulse_ids [$];
logic [CHANNEL_NUM-1:0] prev_valid = '0;
logic [CHANNEL_NUM-1:0] prev_ready = '0;
axis_beat_t             prev_tx [CHANNEL_NUM];
int                     beat_idx [CHANNEL_NUM] = '{default: 0};
int                     frames_done [CHANNEL_NUM] = '{default: 0};

ocs_controller #(
    .P_SLOT_LEN     (SLOT_LEN       ),
    .P_CONFIG_DELAY (CONFIG_DELAY   ),
    .P_FIFO_DEPTH   (FIFO_DEPTH     )
) i_ocs_controller (
    .i_clk          (i_clk          ),
    .i_rst          (i_rst          ),
    .i_chnl_ready   (i_chnl_ready   ),
    .i_tx_ready     (i_tx_ready     ),
    .o_tx           (o_tx           ),
    .o_tx_valid     (o_tx_valid     ),
    .o_slot_id      (o_slot_id      ),
    .o_slot_start   (o_slot_start   )
);

initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
end

// Ready about three cycles in four
always @(posedge i_clk) begin
    logic [31:0] rnd_word;
    if (!i_rst) begin
        rnd_word = $random(seed);
        i_tx_ready <= rnd_word[7:0] | rnd_word[15:8];
    end
end

function automatic axis_beat_t expected_beat(input int ch, input logic id, input int beat);
    axis_beat_t  b;
    logic [47:0] dest;
    dest       = TOR_MAC_BASE;
    dest[15:8] = ch[7:0];
    b.tkeep    = '1;
    b.tlast    = (beat == FRAME_BEATS - 1);
    if (beat == 0) begin
        b.tdata = {dest, CTRL_MAC[47:32]};
    end else if (beat == 1) begin
        b.tdata = {CTRL_MAC[31:0], SLOT_ID_TYPE, 15'd0, id};
    end else begin
        b.tdata = '0;
    end
    return b;
endfunction

////////////////////////////////////////
// Slot timing and frame checks
////////////////////////////////////////

always @(negedge i_clk) begin
    logic       exp_start;
    axis_beat_t exp_beat;
    exp_start = 1'b0;
    if (prev_rst || !prev_all_ready) begin
        model_idle  = 1'b1;
        since_pulse = 0;
        if (prev_rst) begin
            exp_id = 1'b0;
        end
    end else if (model_idle) begin
        // First slot keeps the current id
        model_idle  = 1'b0;
        since_pulse = 0;
        exp_start   = 1'b1;
    end else begin
        since_pulse++;
        if (since_pulse == SLOT_PERIOD) begin
            since_pulse = 0;
            exp_start   = 1'b1;
            exp_id      = ~exp_id;
        end
    end
    checks++;
    assert (o_slot_start === exp_start) else begin
        mismatches++;
        $display("Mismatch o_slot_start: got %h expected %h", o_slot_start, exp_start);
    end
    assert (o_slot_id === exp_id) else begin
        mismatches++;
        $display("Mismatch o_slot_id: got %h expected %h", o_slot_id, exp_id);
    end
    if (exp_start) begin
        pulse_ids.push_back(exp_id);
    end
    for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
        if (prev_rst || pulse_ids.size() == 0) begin
            assert (o_tx_valid[ch] === 1'b0) else begin
                mismatches++;
                $display("Mismatch o_tx_valid ch%0d: got %h expected 0", ch, o_tx_valid[ch]);
            end
        end
        if (prev_valid[ch] && !prev_ready[ch]) begin
            assert (o_tx_valid[ch] === 1'b1 && o_tx[ch] === prev_tx[ch]) else begin
                mismatches++;
                $display("Mismatch o_tx ch%0d under stall: got %h valid %h expected %h valid 1",
                         ch, o_tx[ch], o_tx_valid[ch], prev_tx[ch]);
            end
        end
        if (o_tx_valid[ch] && i_tx_ready[ch]) begin
            if (frames_done[ch] >= pulse_ids.size()) begin
                failures++;
                $display("Channel %0d sent a frame beat without a slot start", ch);
            end else begin
                exp_beat = expected_beat(ch, pulse_ids[frames_done[ch]], beat_idx[ch]);
                assert (o_tx[ch] === exp_beat) else begin
                    mismatches++;
                    $display("Mismatch o_tx ch%0d beat %0d: got %h expected %h",
                             ch, beat_idx[ch], o_tx[ch], exp_beat);
                end
            end
            if (beat_idx[ch] == FRAME_BEATS - 1) begin
                beat_idx[ch] = 0;
                frames_done[ch]++;
            end else begin
                beat_idx[ch]++;
            end
        end
        prev_valid[ch] = o_tx_valid[ch];
        prev_ready[ch] = i_tx_ready[ch];
        prev_tx[ch]    = o_tx[ch];
    end
    prev_rst       = i_rst;
    prev_all_ready = &i_chnl_ready;
end

////////////////////////////////////////
// Waits with timeout
////////////////////////////////////////

task automatic wait_for_pulse(input int max_cycles, input string what);
    int n;
    n = 0;
    if (!aborted) begin
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_slot_start && n < max_cycles);
        if (!o_slot_start) begin
            failures++;
            aborted = 1'b1;
            $display("Timeout waiting for %s", what);
        end
    end
endtask

function automatic logic all_frames_done();
    logic done;
    done = (o_tx_valid == '0);
    for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
        done = done && (beat_idx[ch] == 0) && (frames_done[ch] == pulse_ids.size());
    end
    return done;
endfunction

task automatic wait_for_drain(input int max_cycles);
    int n;
    n = 0;
    if (!aborted) begin
        while (!all_frames_done() && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (all_frames_done()) else begin
            failures++;
            $display("Timeout waiting for all channels to finish their frames");
        end
    end
endtask

initial begin
    seed         = 32'h27cd573a;
    checks       = 0;
    mismatches   = 0;
    failures     = 0;
    aborted      = 1'b0;
    i_rst        = 1'b1;
    i_chnl_ready = '0;
    i_tx_ready   = '1;
    repeat (10) @(posedge i_clk);
    i_rst        <= 1'b0;
    i_chnl_ready <= 8'h7f;
    // Nothing may start while one link is down
    repeat (30) @(posedge i_clk);
    i_chnl_ready <= '1;
    wait_for_pulse(3, "first slot start");
    repeat (4) wait_for_pulse(SLOT_PERIOD + 2, "next slot start");
    // Link 3 lost mid-slot
    repeat (20) @(posedge i_clk);
    i_chnl_ready[3] <= 1'b0;
    repeat (2 * SLOT_PERIOD) @(posedge i_clk);
    i_chnl_ready[3] <= 1'b1;
    wait_for_pulse(3, "slot start after link recovery");
    repeat (3) wait_for_pulse(SLOT_PERIOD + 2, "next slot start");
    @(posedge i_clk);
    i_chnl_ready <= '0;
    wait_for_drain(20 * FRAME_BEATS);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

// File: ocs_controller.sv
`timescale 1ns/100ps

module ocs_controller #(
    parameter int unsigned P_SLOT_LEN     = 23760,
    parameter int unsigned P_CONFIG_DELAY = 2400,
    parameter int unsigned P_FIFO_DEPTH   = 4
)(
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0] i_chnl_ready,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0] i_tx_ready,
    output ocs_pkg::axis_beat_t             o_tx [ocs_pkg::CHANNEL_NUM],
    output logic [ocs_pkg::CHANNEL_NUM-1:0] o_tx_valid,
    output logic                            o_slot_id,
    output logic                            o_slot_start
);

import ocs_pkg::*;

slot_event_t                w_slot_event;
slot_event_t                w_head [CHANNEL_NUM];
logic [CHANNEL_NUM-1:0]     w_head_valid;
logic [CHANNEL_NUM-1:0]     w_head_pop;

assign w_slot_event = '{slot_id: o_slot_id};

ocs_slot_ctrl #(
    .P_SLOT_LEN     (P_SLOT_LEN     ),
    .P_CONFIG_DELAY (P_CONFIG_DELAY )
) ocs_slot_ctrl_u0 (
    .i_clk          (i_clk          ),
    .i_rst          (i_rst          ),
    .i_chnl_ready   (i_chnl_ready   ),
    .o_slot_start   (o_slot_start   ),
    .o_slot_id      (o_slot_id      )
);

////////////////////////////////////////
// Per-ToR channels
////////////////////////////////////////

for (genvar ch = 0; ch < CHANNEL_NUM; ch++) begin : g_chnl
    // Slot strobe is shared, each channel queues it against its own ready
    slot_event_fifo #(
        .P_DEPTH        (P_FIFO_DEPTH       )
    ) slot_event_fifo_u (
        .i_clk          (i_clk              ),
        .i_rst          (i_rst              ),
        .i_push         (o_slot_start       ),
        .i_event        (w_slot_event       ),
        .i_pop          (w_head_pop[ch]     ),
        .o_event        (w_head[ch]         ),
        .o_valid        (w_head_valid[ch]   )
    );

    ocs_sync_tx #(
        .P_CHANNEL      (ch                 )
    ) ocs_sync_tx_u (
        .i_clk          (i_clk              ),
        .i_rst          (i_rst              ),
        .i_event        (w_head[ch]         ),
        .i_event_valid  (w_head_valid[ch]   ),
        .o_event_pop    (w_head_pop[ch]     ),
        .o_tx           (o_tx[ch]           ),
        .o_tx_valid     (o_tx_valid[ch]     ),
        .i_tx_ready     (i_tx_ready[ch]     )
    );
end

endmodule

// File: ocs_sync_tx.sv
`timescale 1ns/100ps

module ocs_sync_tx #(
    parameter int unsigned P_CHANNEL = 0
)(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  ocs_pkg::slot_event_t i_event,
    input  logic                 i_event_valid,
    output logic                 o_event_pop,
    output ocs_pkg::axis_beat_t  o_tx,
    output logic                 o_tx_valid,
    input  logic                 i_tx_ready
);

import ocs_pkg::*;

localparam int BEAT_W = $clog2(FRAME_BEATS);

localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(FRAME_BEATS - 1);

// ToR MAC with the channel index in byte 1
localparam logic [47:0] DEST_MAC = {TOR_MAC_BASE[47:16],
                                    8'(P_CHANNEL),
                                    TOR_MAC_BASE[7:0]};

logic               r_busy;
logic [BEAT_W-1:0]  r_beat;
logic               r_slot_id;
logic               w_xfer;

// Only take a new event between frames
assign o_event_pop = !r_busy && i_event_valid;
assign o_tx_valid  = r_busy;
assign w_xfer      = r_busy && i_tx_ready;

////////////////////////////////////////
// Frame sequencing
////////////////////////////////////////

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        r_busy <= 1'b0;
        r_beat <= '0;
    end else if (o_event_pop) begin
        r_busy <= 1'b1;
        r_beat <= '0;
    end else if (w_xfer) begin
        if (r_beat == LAST_BEAT) begin
            r_busy <= 1'b0;
        end else begin
            r_beat <= r_beat + 1'b1;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (o_event_pop) begin
        r_slot_id <= i_event.slot_id;
    end
end

// Beat contents follow the beat counter only, so they hold under stall
always_comb begin
    o_tx.tkeep = '1;
    o_tx.tlast = (r_beat == LAST_BEAT);
    case (r_beat)
        BEAT_W'(0): begin
            o_tx.tdata = {DEST_MAC, CTRL_MAC[47:32]};
        end
        BEAT_W'(1): begin
            o_tx.tdata = {CTRL_MAC[31:0], SLOT_ID_TYPE, 15'd0, r_slot_id};
        end
        default: begin
            // Padding up to 64 bytes
            o_tx.tdata = '0;
        end
    endcase
end

endmodule

// File: slot_event_fifo.sv
`timescale 1ns/100ps

module slot_event_fifo #(
    parameter int unsigned P_DEPTH = 4
)(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_push,
    input  ocs_pkg::slot_event_t i_event,
    input  logic                 i_pop,
    output ocs_pkg::slot_event_t o_event,
    output logic                 o_valid
);

import ocs_pkg::*;

localparam int PTR_W = (P_DEPTH > 1) ? $clog2(P_DEPTH) : 1;
localparam int CNT_W = $clog2(P_DEPTH + 1);

localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(P_DEPTH - 1);

slot_event_t        r_mem [P_DEPTH];
logic [PTR_W-1:0]   r_wr_ptr;
logic [PTR_W-1:0]   r_rd_ptr;
logic [CNT_W-1:0]   r_count;
logic               w_full;
logic               w_do_push;
logic               w_do_pop;

assign o_valid   = (r_count != '0);
assign o_event   = r_mem[r_rd_ptr];
assign w_full    = (r_count == CNT_W'(P_DEPTH));
assign w_do_pop  = i_pop && o_valid;
// Full FIFO drops the event unless a slot frees up this cycle
assign w_do_push = i_push && (!w_full || w_do_pop);

always_ff @(posedge i_clk) begin
    if (w_do_push) begin
        r_mem[r_wr_ptr] <= i_event;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        r_wr_ptr <= '0;
        r_rd_ptr <= '0;
        r_count  <= '0;
    end else begin
        if (w_do_push) begin
            r_wr_ptr <= (r_wr_ptr == PTR_LAST) ? '0 : r_wr_ptr + 1'b1;
        end
        if (w_do_pop) begin
            r_rd_ptr <= (r_rd_ptr == PTR_LAST) ? '0 : r_rd_ptr + 1'b1;
        end
        case ({w_do_push, w_do_pop})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
        endcase
    end
end

endmodule

// File: ocs_slot_ctrl.sv
`timescale 1ns/100ps

module ocs_slot_ctrl #(
    parameter int unsigned P_SLOT_LEN     = 23760,
    parameter int unsigned P_CONFIG_DELAY = 2400
)(
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic [ocs_pkg::CHANNEL_NUM-1:0] i_chnl_ready,
    output logic                            o_slot_start,
    output logic                            o_slot_id
);

localparam int unsigned CNT_MAX = (P_SLOT_LEN > P_CONFIG_DELAY) ?
                                  P_SLOT_LEN : P_CONFIG_DELAY;
localparam int CNT_W = $clog2(CNT_MAX) + 1;

localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(P_SLOT_LEN - 1);
localparam logic [CNT_W-1:0] CFG_LAST  = CNT_W'(P_CONFIG_DELAY - 1);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_SLOT,
    ST_CONFIG
} state_t;

state_t             r_state;
logic [CNT_W-1:0]   r_cnt;
logic               w_all_ready;

assign w_all_ready = &i_chnl_ready;

////////////////////////////////////////
// Slot / reconfiguration timer
////////////////////////////////////////

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        r_state      <= ST_IDLE;
        r_cnt        <= '0;
        o_slot_start <= 1'b0;
        o_slot_id    <= 1'b0;
    end else if (!w_all_ready) begin
        // Any link lost, start over from idle
        r_state      <= ST_IDLE;
        r_cnt        <= '0;
        o_slot_start <= 1'b0;
    end else begin
        o_slot_start <= 1'b0;
        case (r_state)
            ST_IDLE: begin
                // First slot keeps the current id
                r_state      <= ST_SLOT;
                r_cnt        <= '0;
                o_slot_start <= 1'b1;
            end
            ST_SLOT: begin
                if (r_cnt == SLOT_LAST) begin
                    r_state <= ST_CONFIG;
                    r_cnt   <= '0;
                end else begin
                    r_cnt <= r_cnt + 1'b1;
                end
            end
            ST_CONFIG: begin
                if (r_cnt == CFG_LAST) begin
                    r_state      <= ST_SLOT;
                    r_cnt        <= '0;
                    o_slot_start <= 1'b1;
                    o_slot_id    <= ~o_slot_id;
                end else begin
                    r_cnt <= r_cnt + 1'b1;
                end
            end
            default: begin
                r_state <= ST_IDLE;
                r_cnt   <= '0;
            end
        endcase
    end
end

endmodule

// File: ocs_pkg.sv
package ocs_pkg;

    ////////////////////////////////////////
    // Channel and stream geometry
    ////////////////////////////////////////

    localparam int CHANNEL_NUM = 8;

    localparam int DATA_W      = 64;
    localparam int KEEP_W      = DATA_W / 8;

    // 8 beats of 8 bytes, one minimum-size frame
    localparam int FRAME_BEATS = 8;

    ////////////////////////////////////////
    // Synchronization frame fields
    ////////////////////////////////////////

    localparam logic [15:0] SLOT_ID_TYPE = 16'hff03;

    localparam logic [47:0] CTRL_MAC     = 48'h8D_BC_5C_4A_1A_1F;

    // Byte 1 carries the ToR index
    localparam logic [47:0] TOR_MAC_BASE = 48'h8D_BC_5C_4A_00_00;

    ////////////////////////////////////////
    // Shared structs
    ////////////////////////////////////////

    // One beat on the transmit stream
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
    } axis_beat_t;

    // Slot start as seen by a channel
    typedef struct packed {
        logic slot_id;
    } slot_event_t;

endpackage
